// ==== source/busPkg.sv ====
package busPkg;

	// ==============================
	// register word and map
	// ==============================
	typedef logic [15:0] wordT;

	typedef enum logic [2:0] {
		RegStatus      = 3'd0, // forward flags, switches, turn toggle
		RegSpeed0      = 3'd1,
		RegSpeed1      = 3'd2,
		RegSpeed2      = 3'd3,
		RegSpeed3      = 3'd4,
		RegBeaconStart = 3'd5,
		RegBeaconEnd   = 3'd6,
		RegControl     = 3'd7  // direction inversion mask, only writable one
	} regAddrT;

	// wishbone classic, master side
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		regAddrT adr;
		wordT    datWr;
	} wbRequestT;

	typedef struct packed {
		logic ack;   // single cycle
		wordT datRd; // valid with ack
	} wbResponseT;

endpackage

// ==== source/encoderPkg.sv ====
package encoderPkg;

	// two flops ahead of the edge register
	localparam int SyncStages = 2;

	// ==============================
	// encoder side
	// ==============================
	typedef struct packed {
		logic a;
		logic b;
	} encoderPhasesT;

	typedef struct packed {
		logic riseA;
		logic riseB;
		logic forward; // B level at A rise, after inversion
	} encoderEventsT;

	// ==============================
	// laser turret
	// ==============================
	typedef struct packed {
		logic sign; // beacon seen
		logic sync; // once per turn
		logic step; // turret encoder phase A
	} laserInputsT;

	typedef struct packed {
		busPkg::wordT startStep;
		busPkg::wordT endStep;
	} beaconSpanT;

	typedef enum logic [1:0] {BeaconIdle, BeaconReceiving, BeaconGap} beaconStateT;

endpackage

// ==== source/encoderFrontEnd.sv ====
`timescale 1ns/1ps

module encoderFrontEnd import encoderPkg::*; #(
	parameter int EncoderCount = 4
) (
	input  logic                             CLOCK_50,
	input  logic                             reset,
	input  encoderPhasesT [EncoderCount-1:0] encoders,
	input  laserInputsT                      laser,
	input  logic [4:0]                       limitSwitches,
	input  logic                             start,
	input  logic [EncoderCount-1:0]          invertMask,
	output encoderEventsT [EncoderCount-1:0] events,
	output logic                             signLevel,
	output logic                             syncRise,
	output logic                             stepRise,
	output logic [5:0]                       switchLevels
);

	localparam int EncoderBits = 2 * EncoderCount;
	localparam int EdgeWidth = EncoderBits + 3; // encoders and laser get edges
	localparam int InputWidth = EdgeWidth + 6;  // switches and start are levels only

	logic [InputWidth-1:0] rawIn;
	logic [SyncStages-1:0][InputWidth-1:0] syncChain;
	logic [InputWidth-1:0] levels;
	logic [EdgeWidth-1:0] prevLevels;
	logic [EdgeWidth-1:0] rises;
	logic [EncoderCount-1:0] forwardFlags;
	encoderPhasesT [EncoderCount-1:0] encLevels;
	encoderPhasesT [EncoderCount-1:0] encPrev;
	encoderPhasesT [EncoderCount-1:0] encRises;
	laserInputsT laserLevels;
	laserInputsT laserRises;

	assign rawIn = {start, limitSwitches, laser, encoders};
	assign levels = syncChain[SyncStages-1];

	// ==============================
	// synchronizers, edge register
	// ==============================
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			syncChain <= '0;
			prevLevels <= '0;
			rises <= '0;
		end else begin
			syncChain[0] <= rawIn;
			for (int s = 1; s < SyncStages; s++) begin
				syncChain[s] <= syncChain[s-1];
			end
			prevLevels <= levels[EdgeWidth-1:0];
			rises <= levels[EdgeWidth-1:0] & ~prevLevels; // one cycle pulse
		end
	end

	assign encLevels = levels[EncoderBits-1:0];
	assign encPrev = prevLevels[EncoderBits-1:0];
	assign encRises = rises[EncoderBits-1:0];
	assign laserLevels = levels[EdgeWidth-1:EncoderBits];
	assign laserRises = rises[EdgeWidth-1:EncoderBits];

	// direction sampled on A rise, lands with the riseA pulse
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			forwardFlags <= '0;
		end else begin
			for (int i = 0; i < EncoderCount; i++) begin
				if (encLevels[i].a && !encPrev[i].a)
					forwardFlags[i] <= encLevels[i].b ^ invertMask[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < EncoderCount; i++) begin
			events[i].riseA = encRises[i].a;
			events[i].riseB = encRises[i].b;
			events[i].forward = forwardFlags[i];
		end
	end

	assign signLevel = laserLevels.sign;
	assign syncRise = laserRises.sync;
	assign stepRise = laserRises.step;
	assign switchLevels = levels[InputWidth-1:EdgeWidth]; // {start, switches}

endmodule

// ==== source/speedMeter.sv ====
`timescale 1ns/1ps

module speedMeter import busPkg::*, encoderPkg::*; #(
	parameter int EncoderCount = 4,
	parameter int WindowCycles = 500000
) (
	input  logic                             CLOCK_50,
	input  logic                             reset,
	input  encoderEventsT [EncoderCount-1:0] events,
	output wordT [EncoderCount-1:0]          speeds
);

	localparam int WindowWidth = $clog2(WindowCycles);
	localparam logic [WindowWidth-1:0] LastCycle = WindowWidth'(WindowCycles - 1);

	logic [WindowWidth-1:0] windowCount;
	logic windowEnd;
	logic [EncoderCount-1:0][1:0] pulses;  // [1] phase A, [0] phase B
	wordT [EncoderCount-1:0][1:0] pulseCounts;

	// floor of the A/B mean, sum kept one bit wider
	function automatic wordT averagePulses(input wordT countA, input wordT countB);
		logic [16:0] sum;
		sum = countA + countB;
		return sum[16:1];
	endfunction

	assign windowEnd = (windowCount == LastCycle);

	always_comb begin
		for (int i = 0; i < EncoderCount; i++) begin
			pulses[i] = {events[i].riseA, events[i].riseB};
		end
	end

	// ==============================
	// gate window
	// ==============================
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset)
			windowCount <= '0;
		else
			windowCount <= windowEnd ? '0 : windowCount + 1'b1;
	end

	// a pulse in the last cycle belongs to the next window
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			pulseCounts <= '0;
		end else begin
			for (int i = 0; i < EncoderCount; i++) begin
				for (int p = 0; p < 2; p++) begin
					if (windowEnd)
						pulseCounts[i][p] <= wordT'(pulses[i][p]);
					else
						pulseCounts[i][p] <= pulseCounts[i][p] + wordT'(pulses[i][p]);
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			speeds <= '0; // zero until first window closes
		end else if (windowEnd) begin
			for (int i = 0; i < EncoderCount; i++) begin
				speeds[i] <= averagePulses(pulseCounts[i][1], pulseCounts[i][0]);
			end
		end
	end

endmodule

// ==== source/beaconCapture.sv ====
`timescale 1ns/1ps

module beaconCapture import busPkg::*, encoderPkg::*; #(
	parameter int GlitchSteps = 20
) (
	input  logic       CLOCK_50,
	input  logic       reset,
	input  logic       signLevel,
	input  logic       syncRise,
	input  logic       stepRise,
	output beaconSpanT span,
	output logic       turnToggle
);

	localparam int GapWidth = $clog2(GlitchSteps + 1);

	beaconStateT state;
	beaconStateT nextState;
	wordT stepCount;
	wordT startCandidate;
	wordT endCandidate;
	logic [GapWidth-1:0] gapCount;
	logic gapDone;
	logic receptionStart;
	logic signLost;
	logic receptionEnd;

	assign gapDone = (gapCount == GapWidth'(GlitchSteps));
	assign receptionStart = (state == BeaconIdle) && (nextState == BeaconReceiving);
	assign signLost = (state == BeaconReceiving) && (nextState == BeaconGap);
	assign receptionEnd = (state == BeaconGap) && (nextState == BeaconIdle);

	// ==============================
	// turret position
	// ==============================
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset)
			stepCount <= '0;
		else if (syncRise)
			stepCount <= '0;     // new turn
		else if (stepRise)
			stepCount <= stepCount + 1'b1;
	end

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset)
			turnToggle <= 1'b0;
		else if (syncRise)
			turnToggle <= ~turnToggle;
	end

	// ==============================
	// reception FSM
	// ==============================
	always_comb begin
		nextState = state;
		case (state)
			BeaconIdle:      if (signLevel) nextState = BeaconReceiving;
			BeaconReceiving: if (!signLevel) nextState = BeaconGap;
			BeaconGap: begin
				if (signLevel)
					nextState = BeaconReceiving; // short dropout, keep start
				else if (gapDone)
					nextState = BeaconIdle;
			end
			default: nextState = BeaconIdle;
		endcase
	end

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			state <= BeaconIdle;
			gapCount <= '0;
		end else begin
			state <= nextState;
			if (signLost)
				gapCount <= '0;
			else if (state == BeaconGap && stepRise && !gapDone)
				gapCount <= gapCount + 1'b1; // gap measured in steps
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (receptionStart)
			startCandidate <= stepCount;
		if (signLost)
			endCandidate <= stepCount;   // overwritten if sign comes back
	end

	// publish the pair only once the gap is long enough
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset)
			span <= '0;
		else if (receptionEnd)
			span <= '{startStep: startCandidate, endStep: endCandidate};
	end

endmodule

// ==== source/registerBank.sv ====
`timescale 1ns/1ps

module registerBank import busPkg::*, encoderPkg::*; #(
	parameter int EncoderCount = 4
) (
	input  logic                             CLOCK_50,
	input  logic                             reset,
	input  wbRequestT                        wbIn,
	output wbResponseT                       wbOut,
	input  encoderEventsT [EncoderCount-1:0] events,
	input  logic [5:0]                       switchLevels,
	input  logic                             turnToggle,
	input  wordT [EncoderCount-1:0]          speeds,
	input  beaconSpanT                       span,
	output logic [EncoderCount-1:0]          invertMask
);

	logic access;
	logic ackReg;
	wordT readData;
	wordT readMux;
	wordT statusWord;
	wordT controlReg;

	// new request, not the cycle that is already being acked
	assign access = wbIn.cyc & wbIn.stb & ~ackReg;

	always_comb begin
		statusWord = '0;
		for (int i = 0; i < EncoderCount; i++) begin
			statusWord[i] = events[i].forward;
		end
		statusWord[13:8] = switchLevels; // start on 13
		statusWord[15] = turnToggle;
	end

	always_comb begin
		case (wbIn.adr)
			RegStatus:      readMux = statusWord;
			RegSpeed0, RegSpeed1, RegSpeed2, RegSpeed3:
				readMux = speeds[wbIn.adr - RegSpeed0];
			RegBeaconStart: readMux = span.startStep;
			RegBeaconEnd:   readMux = span.endStep;
			default:        readMux = controlReg;
		endcase
	end

	// ==============================
	// wishbone slave
	// ==============================
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			ackReg <= 1'b0;
			controlReg <= '0;
		end else begin
			ackReg <= access;
			if (access && wbIn.we && wbIn.adr == RegControl)
				controlReg <= wbIn.datWr; // other writes just get acked
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (access)
			readData <= readMux;
	end

	assign wbOut = '{ack: ackReg, datRd: readData};
	assign invertMask = controlReg[EncoderCount-1:0];

endmodule

// ==== source/robotSensorHub.sv ====
`timescale 1ns/1ps

module robotSensorHub import busPkg::*, encoderPkg::*; #(
	parameter int EncoderCount = 4,
	parameter int WindowCycles = 500000, // 10 ms at 50 MHz
	parameter int GlitchSteps = 20
) (
	input  logic                             CLOCK_50,
	input  logic                             reset,
	input  encoderPhasesT [EncoderCount-1:0] encoders,
	input  laserInputsT                      laser,
	input  logic [4:0]                       limitSwitches,
	input  logic                             start,
	input  wbRequestT                        wbIn,
	output wbResponseT                       wbOut
);

	encoderEventsT [EncoderCount-1:0] events;
	logic signLevel;
	logic syncRise;
	logic stepRise;
	logic [5:0] switchLevels;
	logic [EncoderCount-1:0] invertMask;
	wordT [EncoderCount-1:0] speeds;
	beaconSpanT span;
	logic turnToggle;

	// ==============================
	// decode
	// ==============================
	encoderFrontEnd #(.EncoderCount(EncoderCount)) frontEnd (
		.CLOCK_50(CLOCK_50), .reset(reset), .encoders(encoders), .laser(laser),
		.limitSwitches(limitSwitches), .start(start), .invertMask(invertMask),
		.events(events), .signLevel(signLevel), .syncRise(syncRise),
		.stepRise(stepRise), .switchLevels(switchLevels)
	);

	// execute
	speedMeter #(.EncoderCount(EncoderCount), .WindowCycles(WindowCycles)) speedUnit (
		.CLOCK_50(CLOCK_50), .reset(reset), .events(events), .speeds(speeds)
	);

	beaconCapture #(.GlitchSteps(GlitchSteps)) beaconUnit (
		.CLOCK_50(CLOCK_50), .reset(reset), .signLevel(signLevel), .syncRise(syncRise),
		.stepRise(stepRise), .span(span), .turnToggle(turnToggle)
	);

	// result, firmware side
	registerBank #(.EncoderCount(EncoderCount)) registers (
		.CLOCK_50(CLOCK_50), .reset(reset), .wbIn(wbIn), .wbOut(wbOut),
		.events(events), .switchLevels(switchLevels), .turnToggle(turnToggle),
		.speeds(speeds), .span(span), .invertMask(invertMask)
	);

endmodule

// ==== bench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
	parameter real Period = 40.0,
	parameter int ResetCycles = 5
) (
	output logic CLOCK_50,
	output logic reset
);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(Period / 2) CLOCK_50 = ~CLOCK_50;
	end

	// released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge CLOCK_50);
		reset <= 1'b0;
	end

endmodule

// ==== bench/tbSensorHub.sv ====
`timescale 1ns/1ps

module tbSensorHub import busPkg::*, encoderPkg::*; ();

	localparam int EncoderCount = 4;
	localparam int WindowCycles = 400;
	localparam int GlitchSteps = 4;
	localparam int AckTimeout = 20;

	logic CLOCK_50;
	logic reset;
	encoderPhasesT [EncoderCount-1:0] encoders;
	laserInputsT laser;
	logic [4:0] limitSwitches;
	logic start;
	wbRequestT wbIn;
	wbResponseT wbOut;

	int checks;
	int errors;
	int tests;
	int testErrors;
	int syncCount; // sync pulses since reset
	string testName;

	// encoder pattern generator
	logic encRun;
	logic [EncoderCount-1:0] encDirHigh;
	int encPeriod [EncoderCount];
	int encPhase [EncoderCount];

	tbClock clockGen (.CLOCK_50(CLOCK_50), .reset(reset));

	robotSensorHub #(
		.EncoderCount(EncoderCount),
		.WindowCycles(WindowCycles),
		.GlitchSteps(GlitchSteps)
	) UUT (
		.CLOCK_50(CLOCK_50), .reset(reset), .encoders(encoders), .laser(laser),
		.limitSwitches(limitSwitches), .start(start), .wbIn(wbIn), .wbOut(wbOut)
	);

	// B offset in cycles, high at A's rise when dirHigh
	function automatic int bShift(input int period, input logic dirHigh);
		return dirHigh ? period / 4 : period - period / 4;
	endfunction

	// A rises at phase 0, B a quarter period away
	always @(posedge CLOCK_50) begin
		for (int i = 0; i < EncoderCount; i++) begin
			if (encRun) begin
				encPhase[i] <= (encPhase[i] + 1) % encPeriod[i];
				encoders[i].a <= (encPhase[i] < encPeriod[i] / 2);
				encoders[i].b <= ((encPhase[i] + bShift(encPeriod[i], encDirHigh[i]))
					% encPeriod[i]) < encPeriod[i] / 2;
			end
		end
	end

	// ==============================
	// bus protocol checks
	// ==============================
	ackSingleCycle: assert property (@(posedge CLOCK_50) disable iff (reset)
		wbOut.ack |=> !wbOut.ack)
	else begin
		$display("ack was high for two cycles in a row");
		errors++;
	end

	ackAfterRequest: assert property (@(posedge CLOCK_50) disable iff (reset)
		$rose(wbOut.ack) |-> $past(wbIn.cyc && wbIn.stb))
	else begin
		$display("ack rose without cyc and stb in the cycle before");
		errors++;
	end

	task automatic waitCycles(input int count);
		repeat (count) @(posedge CLOCK_50);
	endtask

	task automatic abortRun(input string reason);
		$display("timeout: %s", reason);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic busAccess(input regAddrT adr, input logic we, input wordT datWr,
			output wordT datRd);
		int waited;
		@(posedge CLOCK_50);
		wbIn <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datWr: datWr};
		waited = 0;
		do begin
			@(negedge CLOCK_50); // ack and data settled here
			waited++;
		end while (!wbOut.ack && waited < AckTimeout);
		if (!wbOut.ack) begin
			abortRun($sformatf("no ack on access to %s", adr.name()));
		end else begin
			datRd = wbOut.datRd;
			@(posedge CLOCK_50);
			wbIn <= '0;
		end
	endtask

	task automatic wbRead(input regAddrT adr, output wordT data);
		busAccess(adr, 1'b0, '0, data);
	endtask

	task automatic wbWrite(input regAddrT adr, input wordT data);
		wordT unused;
		busAccess(adr, 1'b1, data, unused);
	endtask

	task automatic checkValue(input string name, input wordT got, input wordT expected);
		checks++;
		assert (got === expected) else begin
			$display("Error: %s = %h, expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic checkNear(input string name, input wordT got, input wordT expected);
		checks++;
		assert (int'(got) >= int'(expected) - 1 && int'(got) <= int'(expected) + 1) else begin
			$display("Error: %s = %h, expected %h within one", name, got, expected);
			errors++;
		end
	endtask

	task automatic checkIdle();
		checks++;
		assert (UUT.beaconUnit.state == BeaconIdle) else begin
			$display("beacon FSM is in %s, not back in idle", UUT.beaconUnit.state.name());
			errors++;
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrors = errors;
		tests++;
	endtask

	task automatic finishTest();
		$display("%s: %s, %0d errors", testName,
			(errors == testErrors) ? "ok" : "failed", errors - testErrors);
	endtask

	// ==============================
	// laser turret stimulus
	// ==============================
	task automatic laserSteps(input int count);
		repeat (count) begin
			@(posedge CLOCK_50);
			laser.step <= 1'b1;
			waitCycles(4);
			laser.step <= 1'b0;
			waitCycles(4);
		end
	endtask

	task automatic pulseSync();
		@(posedge CLOCK_50);
		laser.sync <= 1'b1;
		waitCycles(4);
		laser.sync <= 1'b0;
		waitCycles(4);
		syncCount++;
	endtask

	task automatic setSign(input logic level);
		@(posedge CLOCK_50);
		laser.sign <= level;
		waitCycles(4); // through sync and FSM
	endtask

	initial begin
		wordT data;
		wordT expected;
		regAddrT adr;
		int waited;
		int ch;
		int s, m1, m2, e, k, s2;
		logic [4:0] sw;
		logic st;

		void'($urandom(32'h85fd));
		encoders = '0;
		laser = '0;
		limitSwitches = '0;
		start = 1'b0;
		wbIn = '0;
		encRun = 1'b0;
		encDirHigh = '1;
		for (int i = 0; i < EncoderCount; i++) begin
			encPeriod[i] = 8;
			encPhase[i] = 0;
		end
		checks = 0;
		errors = 0;
		tests = 0;
		syncCount = 0;

		waited = 0;
		while (reset !== 1'b0 && waited < 20) begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (reset !== 1'b0)
			abortRun("reset was never released");

		beginTest("reset and bus protocol");
		for (int i = 0; i < 8; i++) begin
			adr = regAddrT'(i);
			wbRead(adr, data);
			checkValue(adr.name(), data, '0); // everything clear after reset
		end
		wbWrite(RegSpeed0, 16'hbeef);
		wbRead(RegSpeed0, data);
		checkValue("RegSpeed0 after write", data, '0);
		wbRead(RegControl, data); // ignored write must not land here
		checkValue("RegControl after write", data, '0);
		finishTest();

		beginTest("speed");
		for (int i = 0; i < EncoderCount; i++)
			encPeriod[i] = 8 + $urandom % 33;
		@(posedge CLOCK_50);
		encRun <= 1'b1;
		waitCycles(3 * WindowCycles); // last window fully covered
		for (int i = 0; i < EncoderCount; i++) begin
			wbRead(regAddrT'(RegSpeed0 + i), data);
			checkNear($sformatf("speed%0d", i), data, wordT'(WindowCycles / encPeriod[i]));
		end
		finishTest();

		beginTest("direction and mask");
		ch = $urandom % EncoderCount;
		for (int dir = 1; dir >= 0; dir--) begin
			@(posedge CLOCK_50);
			encDirHigh <= {EncoderCount{dir[0]}};
			wbWrite(RegControl, '0);
			waitCycles(120); // a few A rises at the longest period
			expected = wordT'({EncoderCount{dir[0]}});
			wbRead(RegStatus, data);
			checkValue("status forward", data & 16'h000f, expected);
			wbWrite(RegControl, wordT'(1 << ch));
			wbRead(RegControl, data);
			checkValue("RegControl", data, wordT'(1 << ch));
			waitCycles(120);
			wbRead(RegStatus, data);
			checkValue("status forward inverted", data & 16'h000f, expected ^ wordT'(1 << ch));
		end
		wbWrite(RegControl, '0);
		finishTest();

		beginTest("beacon with glitch");
		s = 1 + $urandom % 8;
		m1 = 1 + $urandom % 6;
		m2 = 1 + $urandom % 6;
		pulseSync();
		laserSteps(s);
		setSign(1'b1);
		laserSteps(m1);
		setSign(1'b0);
		laserSteps(2);    // short dropout
		setSign(1'b1);
		laserSteps(m2);
		setSign(1'b0);
		e = s + m1 + 2 + m2;
		laserSteps(GlitchSteps);
		wbRead(RegBeaconStart, data);
		checkValue("RegBeaconStart", data, wordT'(s));
		wbRead(RegBeaconEnd, data);
		checkValue("RegBeaconEnd", data, wordT'(e));
		checkIdle();
		finishTest();

		beginTest("beacon dropout");
		s = 1 + $urandom % 8;
		pulseSync();
		laserSteps(s);
		setSign(1'b1);
		laserSteps(m1);
		setSign(1'b0);
		laserSteps(GlitchSteps);
		wbRead(RegBeaconStart, data);
		checkValue("RegBeaconStart first", data, wordT'(s));
		wbRead(RegBeaconEnd, data);
		checkValue("RegBeaconEnd first", data, wordT'(s + m1));
		k = 1 + $urandom % 4;
		laserSteps(k);
		s2 = s + m1 + GlitchSteps + k;
		setSign(1'b1);
		laserSteps(m2);
		setSign(1'b0);
		laserSteps(GlitchSteps - 1);
		wbRead(RegBeaconStart, data); // gap still too short
		checkValue("RegBeaconStart held", data, wordT'(s));
		laserSteps(1);
		wbRead(RegBeaconStart, data);
		checkValue("RegBeaconStart second", data, wordT'(s2));
		wbRead(RegBeaconEnd, data);
		checkValue("RegBeaconEnd second", data, wordT'(s2 + m2));
		checkIdle();
		finishTest();

		beginTest("status inputs");
		repeat (3) begin
			sw = 5'($urandom);
			st = 1'($urandom);
			@(posedge CLOCK_50);
			limitSwitches <= sw;
			start <= st;
			pulseSync();
			wbRead(RegStatus, data);
			expected = {syncCount[0], 1'b0, st, sw, 8'h00};
			checkValue("status switches and toggle", data & 16'hff00, expected);
		end
		finishTest();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
source/busPkg.sv
source/encoderPkg.sv
source/encoderFrontEnd.sv
source/speedMeter.sv
source/beaconCapture.sv
source/registerBank.sv
source/robotSensorHub.sv
bench/tbClock.sv
bench/tbSensorHub.sv
